/* fb_top.f */
+incdir+.
fb_pkg.sv
wb_pkg.sv
pattern_pixel.sv
pattern_stacker.sv
block_fifo.sv
fb_writer.sv
fb_scanout.sv
wb_arbiter.sv
fb_memory.sv
fb_top.sv
tb_fb_top.sv

/* Bender.yml */
package:
  name: fb_top

sources:
  # frame buffer RTL, packages first
  - files:
      - fb_pkg.sv
      - wb_pkg.sv
      - pattern_pixel.sv
      - pattern_stacker.sv
      - block_fifo.sv
      - fb_writer.sv
      - fb_scanout.sv
      - wb_arbiter.sv
      - fb_memory.sv
      - fb_top.sv
  # testbench, tasks come in through the include directory
  - target: test
    include_dirs:
      - .
    files:
      - tb_fb_top.sv

/* tb_fb_tasks.svh */
`ifndef TB_FB_TASKS_SVH
`define TB_FB_TASKS_SVH

// stops at the first mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("Errors found");
    $fatal(1);
  end
endtask

// inputs change 1 ns after the rising edge
task automatic next_cycle();
  @(posedge clk_in);
  #1;
endtask

// expected rgb565 colour at one frame position
function automatic logic [15:0] pattern_ref(input logic [1:0] sel, input int h,
                                            input int v);
  logic [7:0] r8;
  logic [7:0] g8;
  logic [7:0] b8;
  r8 = 8'h00;
  g8 = 8'h00;
  b8 = 8'h00;
  case (sel)
    PAT_SOLID: begin
      r8 = 8'hFF;
      b8 = 8'hFF;
    end
    PAT_CROSS: begin
      // centre column or centre line is white
      if (h == H_PIXELS / 2 || v == V_LINES / 2) begin
        r8 = 8'hFF;
        g8 = 8'hFF;
        b8 = 8'hFF;
      end
    end
    PAT_HRAMP: begin
      r8 = 8'(h * 4);
      g8 = 8'(h * 4);
      b8 = 8'(h * 4);
    end
    default: begin
      r8 = 8'(h * 4);
      g8 = 8'(v * 32);
      // 8-bit wrap of the sum
      b8 = 8'(h * 4 + v * 32);
    end
  endcase
  return {r8[7:3], g8[7:2], b8[7:3]};
endfunction

// render one frame and wait for its done pulse
task automatic write_frame(input logic [1:0] sel);
  int done_before;
  done_before = frame_done_count;
  pattern_sel = sel;
  frame_start = 1'b1;
  next_cycle();
  frame_start = 1'b0;
  while (frame_done_count == done_before) begin
    next_cycle();
  end
  // single cycle pulse
  check_value("frame_done", frame_done, 1'b0);
endtask

// stream one frame out, pixels compared in raster order
task automatic scan_frame(input logic [1:0] sel, input bit random_ready,
                          input bit with_write);
  int idx;
  logic [31:0] rnd;
  logic ready_now;
  idx = 0;
  scan_start = 1'b1;
  // optional rewrite launched in the same cycle
  if (with_write) begin
    pattern_sel = sel;
    frame_start = 1'b1;
  end
  next_cycle();
  scan_start  = 1'b0;
  frame_start = 1'b0;
  while (!scan_done) begin
    if (random_ready) begin
      rnd = $random(seed);
      ready_now = rnd[0];
    end else begin
      ready_now = 1'b1;
    end
    pix_ready = ready_now;
    // handshake lands on the coming edge
    if (pix_valid && ready_now) begin
      check_value("pix_data", pix_data,
                  pattern_ref(sel, idx % H_PIXELS, idx / H_PIXELS));
      check_value("pix_last", pix_last, idx == FRAME_PIXELS - 1);
      idx++;
    end
    next_cycle();
  end
  pix_ready = 1'b0;
  check_value("pixel handshakes", idx, FRAME_PIXELS);
endtask

task automatic test_reset_state();
  check_value("pix_valid", pix_valid, 1'b0);
  check_value("pix_last", pix_last, 1'b0);
  check_value("frame_done", frame_done, 1'b0);
  check_value("scan_done", scan_done, 1'b0);
endtask

task automatic test_solid_frame();
  write_frame(PAT_SOLID);
  // every pixel magenta
  scan_frame(PAT_SOLID, 1'b0, 1'b0);
endtask

task automatic test_cross_frame();
  write_frame(PAT_CROSS);
  scan_frame(PAT_CROSS, 1'b0, 1'b0);
endtask

task automatic test_ramp_and_mix();
  write_frame(PAT_HRAMP);
  scan_frame(PAT_HRAMP, 1'b0, 1'b0);
  write_frame(PAT_MIX);
  scan_frame(PAT_MIX, 1'b0, 1'b0);
endtask

// memory still holds the mix frame
task automatic test_random_ready();
  scan_frame(PAT_MIX, 1'b1, 1'b0);
endtask

// scanout and rewrite contend for the memory
task automatic test_concurrent_access();
  int done_before;
  done_before = frame_done_count;
  scan_frame(PAT_MIX, 1'b0, 1'b1);
  // write may still be draining
  while (frame_done_count == done_before) begin
    next_cycle();
  end
  check_value("frame_done_count", frame_done_count - done_before, 1);
endtask

`endif

/* tb_fb_top.sv */
module tb_fb_top
  import fb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_PIXELS = H_PIXELS * V_LINES;
  // one test is about 12 cycles per block written plus 4 per pixel scanned
  localparam int TEST_CYCLES = BLOCKS_PER_FRAME * 12 + FRAME_PIXELS * 4;
  // six tests at twice TEST_CYCLES, rounded up to a multiple of 10000
  localparam int MAX_CYCLES = (6 * TEST_CYCLES * 2 + 9999) / 10000 * 10000;

  logic clk_in = 1'b0;
  logic rst_n;
  logic frame_start;
  logic [1:0] pattern_sel;
  logic frame_done;
  logic scan_start;
  logic scan_done;
  logic pix_valid;
  logic pix_ready;
  pixel_t pix_data;
  logic pix_last;

  // fixed seed, repeatable back-pressure
  integer seed = 32'h5cd7_04c5;
  int cycle_count = 0;
  // frame_done pulses seen so far
  int frame_done_count = 0;

  // 8 ns clock
  always #4 clk_in = ~clk_in;

  fb_top u_dut (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .frame_start(frame_start),
    .pattern_sel(pattern_sel),
    .frame_done (frame_done),
    .scan_start (scan_start),
    .scan_done  (scan_done),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_data   (pix_data),
    .pix_last   (pix_last)
  );

  // count completions, also catches writes that end mid scan
  always @(posedge clk_in) begin
    if (frame_done) begin
      frame_done_count <= frame_done_count + 1;
    end
  end

  // run limit
  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1);
    end
  end

  `include "tb_fb_tasks.svh"

  initial begin
    // all inputs quiet, reset held
    rst_n       = 1'b0;
    frame_start = 1'b0;
    pattern_sel = PAT_SOLID;
    scan_start  = 1'b0;
    pix_ready   = 1'b0;
    repeat (5) @(posedge clk_in);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_solid_frame();
    test_cross_frame();
    test_ramp_and_mix();
    test_random_ready();
    test_concurrent_access();

    $display("No errors");
    $finish;
  end

endmodule

/* fb_top.sv */
module fb_top
  import fb_pkg::*;
  import wb_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_n,
  input  logic       frame_start,
  input  logic [1:0] pattern_sel,
  output logic       frame_done,
  input  logic       scan_start,
  output logic       scan_done,
  output logic       pix_valid,
  input  logic       pix_ready,
  output pixel_t     pix_data,
  output logic       pix_last
);

  // master side bus
  wire [WB_MASTERS-1:0] m_cyc;
  wire [WB_MASTERS-1:0] m_stb;
  wire [WB_MASTERS-1:0] m_we;
  wire [WB_MASTERS-1:0] m_ack;
  wire [WB_ADR_W-1:0] m_adr [WB_MASTERS];
  wire [WB_DAT_W-1:0] m_dat_w [WB_MASTERS];
  wire [WB_DAT_W-1:0] m_dat_r [WB_MASTERS];

  // slave side bus
  wire s_cyc;
  wire s_stb;
  wire s_we;
  wire s_ack;
  wire [WB_ADR_W-1:0] s_adr;
  wire [WB_DAT_W-1:0] s_dat_w;
  wire [WB_DAT_W-1:0] s_dat_r;

  // scanout only reads
  assign m_dat_w[M_SCANOUT] = '0;

  fb_writer u_writer (
    .clk_in(clk_in), .rst_n(rst_n),
    .frame_start(frame_start), .pattern_sel(pattern_sel), .frame_done(frame_done),
    .wb_cyc(m_cyc[M_WRITER]), .wb_stb(m_stb[M_WRITER]), .wb_we(m_we[M_WRITER]),
    .wb_adr(m_adr[M_WRITER]), .wb_dat_w(m_dat_w[M_WRITER]), .wb_ack(m_ack[M_WRITER])
  );

  fb_scanout u_scanout (
    .clk_in(clk_in), .rst_n(rst_n), .scan_start(scan_start), .scan_done(scan_done),
    .wb_cyc(m_cyc[M_SCANOUT]), .wb_stb(m_stb[M_SCANOUT]), .wb_we(m_we[M_SCANOUT]),
    .wb_adr(m_adr[M_SCANOUT]), .wb_dat_r(m_dat_r[M_SCANOUT]), .wb_ack(m_ack[M_SCANOUT]),
    .pix_valid(pix_valid), .pix_ready(pix_ready), .pix_data(pix_data), .pix_last(pix_last)
  );

  wb_arbiter u_arbiter (
    .clk_in(clk_in), .rst_n(rst_n),
    .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we), .m_adr(m_adr), .m_dat_w(m_dat_w),
    .m_ack(m_ack), .m_dat_r(m_dat_r),
    .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr), .s_dat_w(s_dat_w),
    .s_dat_r(s_dat_r), .s_ack(s_ack)
  );

  fb_memory u_memory (
    .clk_in(clk_in), .rst_n(rst_n),
    .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
    .dat_w(s_dat_w), .dat_r(s_dat_r), .ack(s_ack)
  );

endmodule

/* fb_memory.sv */
module fb_memory
  import fb_pkg::*;
  import wb_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [WB_ADR_W-1:0] adr,
  input  logic [WB_DAT_W-1:0] dat_w,
  output logic [WB_DAT_W-1:0] dat_r,
  output logic                ack
);

  block_t mem [BLOCKS_PER_FRAME];
  block_addr_t idx;
  logic req;

  // word index from the top address bits
  assign idx = adr[WB_ADR_W-1 -: $bits(block_addr_t)];
  // new request, not yet acked
  assign req = cyc && stb && !ack;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk_in) begin
    if (req) begin
      if (we) begin
        mem[idx] <= dat_w;
      end
      dat_r <= mem[idx];
    end
  end

endmodule

/* wb_arbiter.sv */
module wb_arbiter
  import wb_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic [WB_MASTERS-1:0] m_cyc,
  input  logic [WB_MASTERS-1:0] m_stb,
  input  logic [WB_MASTERS-1:0] m_we,
  input  logic [WB_ADR_W-1:0]   m_adr   [WB_MASTERS],
  input  logic [WB_DAT_W-1:0]   m_dat_w [WB_MASTERS],
  output logic [WB_MASTERS-1:0] m_ack,
  output logic [WB_DAT_W-1:0]   m_dat_r [WB_MASTERS],
  output logic                  s_cyc,
  output logic                  s_stb,
  output logic                  s_we,
  output logic [WB_ADR_W-1:0]   s_adr,
  output logic [WB_DAT_W-1:0]   s_dat_w,
  input  logic [WB_DAT_W-1:0]   s_dat_r,
  input  logic                  s_ack
);

  logic granted;
  // current owner, kept after release as last served
  logic [$clog2(WB_MASTERS)-1:0] owner;
  logic [$clog2(WB_MASTERS)-1:0] cand;
  logic [$clog2(WB_MASTERS)-1:0] pick;
  logic found;

  // search starts just after the last served master
  always_comb begin
    cand  = owner;
    pick  = owner;
    found = 1'b0;
    for (int k = 0; k < WB_MASTERS; k++) begin
      cand = (cand == WB_MASTERS - 1) ? '0 : cand + 1'b1;
      if (!found && m_cyc[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      granted <= 1'b0;
      owner   <= '0;
    end else if (granted) begin
      // cycle over when the owner drops cyc
      if (!m_cyc[owner]) begin
        granted <= 1'b0;
      end
    end else if (found) begin
      granted <= 1'b1;
      owner   <= pick;
    end
  end

  // slave side follows the owner
  assign s_cyc   = granted && m_cyc[owner];
  assign s_stb   = granted && m_stb[owner];
  assign s_we    = m_we[owner];
  assign s_adr   = m_adr[owner];
  assign s_dat_w = m_dat_w[owner];

  always_comb begin
    for (int i = 0; i < WB_MASTERS; i++) begin
      m_ack[i]   = s_ack && granted && (owner == i);
      m_dat_r[i] = s_dat_r;
    end
  end

  // ack lands only on a master that already held the grant
  assert property (@(posedge clk_in) disable iff (!rst_n)
    s_ack |-> granted && $past(granted) && $stable(owner) && m_stb[owner]);

endmodule

/* fb_scanout.sv */
module fb_scanout
  import fb_pkg::*;
  import wb_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_n,
  input  logic                scan_start,
  output logic                scan_done,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_r,
  input  logic                wb_ack,
  output logic                pix_valid,
  input  logic                pix_ready,
  output pixel_t              pix_data,
  output logic                pix_last
);

  typedef logic [$clog2(PIX_PER_BLOCK+1)-1:0] unstack_cnt_t;

  logic busy;
  logic rd_active;
  block_addr_t rd_blk;
  block_t unstack_q;
  unstack_cnt_t unstack_cnt;
  logic [$clog2(PIX_FIFO_DEPTH+1)-1:0] fifo_count;
  logic [$clog2(BLOCKS_PER_FRAME*PIX_PER_BLOCK)-1:0] out_cnt;
  logic fifo_empty;
  logic pix_push;
  logic pix_fire;
  logic rd_ack;
  logic issue;

  assign rd_ack = wb_cyc && wb_ack;
  // new read only with room for a whole block and the unstacker idle
  assign issue = rd_active && !wb_cyc && (unstack_cnt == 0) &&
                 (fifo_count <= PIX_FIFO_DEPTH - PIX_PER_BLOCK);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      rd_active <= 1'b0;
      rd_blk    <= '0;
      out_cnt   <= '0;
      scan_done <= 1'b0;
    end else begin
      scan_done <= pix_fire && pix_last;
      if (scan_start && !busy) begin
        busy      <= 1'b1;
        rd_active <= 1'b1;
        rd_blk    <= '0;
        out_cnt   <= '0;
      end else begin
        if (rd_ack) begin
          rd_blk <= rd_blk + 1'b1;
          // block 63 read, nothing more to fetch
          if (rd_blk == BLOCKS_PER_FRAME - 1) begin
            rd_active <= 1'b0;
          end
        end
        if (pix_fire) begin
          out_cnt <= out_cnt + 1'b1;
        end
        if (pix_fire && pix_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // classic read, dropped the cycle after ack
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (rd_ack) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (issue) begin
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
    end
  end

  assign wb_we  = 1'b0;
  assign wb_adr = WB_ADR_W'(rd_blk) << $clog2(WB_DAT_W / 8);

  // unstack counter, eight pushes per block
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      unstack_cnt <= '0;
    end else if (rd_ack) begin
      unstack_cnt <= unstack_cnt_t'(PIX_PER_BLOCK);
    end else if (unstack_cnt != 0) begin
      unstack_cnt <= unstack_cnt - 1'b1;
    end
  end

  // least significant pixel leaves first
  always_ff @(posedge clk_in) begin
    if (rd_ack) begin
      unstack_q <= wb_dat_r;
    end else if (unstack_cnt != 0) begin
      unstack_q <= block_t'(unstack_q >> $bits(pixel_t));
    end
  end

  assign pix_push = (unstack_cnt != 0);

  block_fifo #(
    .T    (pixel_t),
    .DEPTH(PIX_FIFO_DEPTH)
  ) u_pix_fifo (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .push  (pix_push),
    .wdata (unstack_q[0]),
    .full  (),
    .pop   (pix_fire),
    .rdata (pix_data),
    .empty (fifo_empty),
    .count (fifo_count)
  );

  assign pix_valid = !fifo_empty;
  assign pix_fire  = pix_valid && pix_ready;
  // 512th pixel of the frame
  assign pix_last  = pix_valid && (out_cnt == BLOCKS_PER_FRAME * PIX_PER_BLOCK - 1);

  // stream holds under back-pressure
  assert property (@(posedge clk_in) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_last));

endmodule

/* fb_writer.sv */
module fb_writer
  import fb_pkg::*;
  import wb_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_n,
  input  logic                frame_start,
  input  logic [1:0]          pattern_sel,
  output logic                frame_done,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [WB_ADR_W-1:0] wb_adr,
  output logic [WB_DAT_W-1:0] wb_dat_w,
  input  logic                wb_ack
);

  // one queued write, index and payload
  typedef struct packed {
    block_addr_t addr;
    block_t      data;
  } wr_entry_t;

  logic busy;
  logic stacking;
  logic restart;
  logic [1:0] pat_q;
  logic stk_valid;
  logic stk_ready;
  logic stk_last;
  block_addr_t stk_addr;
  block_t stk_block;
  logic push;
  logic pop;
  logic fifo_full;
  logic fifo_empty;
  wr_entry_t head;
  logic last_ack;

  // start only from idle
  assign restart = frame_start && !busy;
  assign stk_ready = !fifo_full;
  assign push = stk_valid && stk_ready;
  // retire the head on ack
  assign pop = wb_cyc && wb_ack;
  // final block written, all blocks already stacked
  assign last_ack = pop && !stacking && (head.addr == BLOCKS_PER_FRAME - 1);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      stacking   <= 1'b0;
      pat_q      <= PAT_SOLID;
      frame_done <= 1'b0;
    end else begin
      frame_done <= last_ack;
      if (restart) begin
        busy     <= 1'b1;
        stacking <= 1'b1;
        pat_q    <= pattern_sel;
      end else begin
        if (push && stk_last) begin
          stacking <= 1'b0;
        end
        if (last_ack) begin
          busy <= 1'b0;
        end
      end
    end
  end

  pattern_stacker u_stacker (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .restart   (restart),
    .sel       (pat_q),
    .ready     (stk_ready),
    .valid     (stk_valid),
    .block_addr(stk_addr),
    .block     (stk_block),
    .last      (stk_last)
  );

  block_fifo #(
    .T    (wr_entry_t),
    .DEPTH(WR_FIFO_DEPTH)
  ) u_fifo (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .push  (push),
    .wdata ('{addr: stk_addr, data: stk_block}),
    .full  (fifo_full),
    .pop   (pop),
    .rdata (head),
    .empty (fifo_empty),
    .count ()
  );

  // one classic write per fifo entry, idle one cycle after each ack
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (wb_cyc && wb_ack) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (!wb_cyc && !fifo_empty) begin
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
    end
  end

  assign wb_we    = 1'b1;
  assign wb_adr   = WB_ADR_W'(head.addr) << $clog2(WB_DAT_W / 8);
  assign wb_dat_w = head.data;

  assert property (@(posedge clk_in) disable iff (!rst_n) wb_stb |-> wb_cyc);
  // head must not move under a pending write
  assert property (@(posedge clk_in) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w));

endmodule

/* block_fifo.sv */
module block_fifo #(
  parameter type T = logic [15:0],
  parameter int DEPTH = 4
) (
  input  logic                       clk_in,
  input  logic                       rst_n,
  input  logic                       push,
  input  T                           wdata,
  output logic                       full,
  input  logic                       pop,
  output T                           rdata,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  T mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;

  // head always visible, first word falls through
  assign rdata = mem[rd_ptr];
  assign empty = (count == 0);
  assign full  = (count == DEPTH);

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // net occupancy change
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // overflow and underflow guards for both users
  assert property (@(posedge clk_in) disable iff (!rst_n) full |-> !push);
  assert property (@(posedge clk_in) disable iff (!rst_n) empty |-> !pop);

endmodule

/* pattern_stacker.sv */
module pattern_stacker
  import fb_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        restart,
  input  logic [1:0]  sel,
  input  logic        ready,
  output logic        valid,
  output block_addr_t block_addr,
  output block_t      block,
  output logic        last
);

  logic armed;
  logic [$clog2(BLOCKS_PER_LINE)-1:0] col;
  logic [$clog2(V_LINES)-1:0] line;
  logic advance;

  // block accepted by the fifo this cycle
  assign advance = valid && ready;
  assign valid = armed;

  // raster order, column fastest
  assign block_addr = {line, col};
  assign last = (col == BLOCKS_PER_LINE - 1) && (line == V_LINES - 1);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      armed <= 1'b0;
      col   <= '0;
      line  <= '0;
    end else if (restart) begin
      armed <= 1'b1;
      col   <= '0;
      line  <= '0;
    end else if (advance) begin
      if (col == BLOCKS_PER_LINE - 1) begin
        col  <= '0;
        line <= line + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
      // frame finished, wait for the next restart
      if (last) begin
        armed <= 1'b0;
      end
    end
  end

  // eight generators side by side, one per pixel of the block
  for (genvar i = 0; i < PIX_PER_BLOCK; i++) begin : g_pix
    logic [5:0] hcount;

    // column times 8 plus lane
    assign hcount = {col, 3'(i)};

    pattern_pixel u_pixel (
      .sel   (sel),
      .hcount(hcount),
      .vcount(line),
      .pixel (block[i])
    );
  end

endmodule

/* pattern_pixel.sv */
module pattern_pixel
  import fb_pkg::*;
(
  input  logic [1:0] sel,
  input  logic [5:0] hcount,
  input  logic [2:0] vcount,
  output pixel_t     pixel
);

  // 8-bit colours before reduction to 565
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;

  always_comb begin
    red   = 8'h00;
    green = 8'h00;
    blue  = 8'h00;
    case (sel)
      PAT_SOLID: begin
        // magenta
        red  = 8'hFF;
        blue = 8'hFF;
      end
      PAT_CROSS: begin
        // one white column and one white line through the centre
        if (hcount == H_PIXELS / 2 || vcount == V_LINES / 2) begin
          red   = 8'hFF;
          green = 8'hFF;
          blue  = 8'hFF;
        end
      end
      PAT_HRAMP: begin
        // grey ramp, 4 steps per pixel
        red   = {hcount, 2'b00};
        green = {hcount, 2'b00};
        blue  = {hcount, 2'b00};
      end
      PAT_MIX: begin
        red   = {hcount, 2'b00};
        green = {vcount, 5'b00000};
        // sum wraps at 8 bits
        blue  = red + green;
      end
    endcase
  end

  // keep the top bits of each colour
  assign pixel = {red[7:3], green[7:2], blue[7:3]};

endmodule

/* wb_pkg.sv */
package wb_pkg;

  // byte address, one 128-bit word per block
  // block index lives in bits 9:4
  localparam int WB_ADR_W = 10;
  localparam int WB_DAT_W = 128;

  // masters on the shared frame memory
  localparam int WB_MASTERS = 2;
  localparam int M_WRITER = 0;
  localparam int M_SCANOUT = 1;

endpackage

/* fb_pkg.sv */
package fb_pkg;

  // frame geometry, kept small for simulation
  localparam int H_PIXELS = 64;
  localparam int V_LINES = 8;
  localparam int PIX_PER_BLOCK = 8;
  localparam int BLOCKS_PER_LINE = H_PIXELS / PIX_PER_BLOCK;
  localparam int BLOCKS_PER_FRAME = BLOCKS_PER_LINE * V_LINES;

  // fifo depths along the frame path
  localparam int WR_FIFO_DEPTH = 4;
  localparam int PIX_FIFO_DEPTH = 16;

  // rgb565, red on top
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } pixel_t;

  // pixel 0 sits in bits 15:0
  typedef pixel_t [PIX_PER_BLOCK-1:0] block_t;

  typedef logic [$clog2(BLOCKS_PER_FRAME)-1:0] block_addr_t;

  // pattern select codes
  localparam logic [1:0] PAT_SOLID = 2'd0;
  localparam logic [1:0] PAT_CROSS = 2'd1;
  localparam logic [1:0] PAT_HRAMP = 2'd2;
  localparam logic [1:0] PAT_MIX = 2'd3;

endpackage
